//--- fifo_demo_pkg.sv
// fifo demo shared definitions for entry width, key requests, segment signs and push data
`default_nettype none

package fifo_demo_pkg;

  // width of one fifo entry, the pattern table below is built for nibbles
  localparam int fifo_width = 4;

  // request decoded from the two key pairs on a sampling tick
  typedef enum logic [1:0]
  {
    req_idle     = 2'd0,
    req_push     = 2'd1,
    req_pop      = 2'd2,
    req_push_pop = 2'd3
  } req_t;

  // fixed sequence of nibbles pushed into the fifo, indexed by the write index
  localparam logic [fifo_width - 1:0] pattern_table [0:15] =
    '{ 4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
       4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3 };

  //----------------------------------------------------------------------
  // seven-segment encoding, abcdefgh with segment a in bit 7

  // top bar only
  localparam logic [7:0] sign_full  = 8'b1000_0000;
  // bottom bar only
  localparam logic [7:0] sign_empty = 8'b0001_0000;

  // hex digit to segments, dot always off
  function automatic logic [7:0] hex_segments (input logic [fifo_width - 1:0] nibble);
    logic [7:0] seg;
    case (nibble)
      4'h0: seg = 8'b1111_1100;
      4'h1: seg = 8'b0110_0000;
      4'h2: seg = 8'b1101_1010;
      4'h3: seg = 8'b1111_0010;
      4'h4: seg = 8'b0110_0110;
      4'h5: seg = 8'b1011_0110;
      4'h6: seg = 8'b1011_1110;
      4'h7: seg = 8'b1110_0000;
      4'h8: seg = 8'b1111_1110;
      4'h9: seg = 8'b1111_0110;
      4'ha: seg = 8'b1110_1110;
      4'hb: seg = 8'b0011_1110;
      4'hc: seg = 8'b1001_1100;
      4'hd: seg = 8'b0111_1010;
      4'he: seg = 8'b1001_1110;
      default: seg = 8'b1000_1110;
    endcase
    return seg;
  endfunction

endpackage

`default_nettype wire

//--- tick_gen.sv
// sampling tick generator, one-cycle enable pulse every 2**tick_log clock cycles
`timescale 1ns/100ps
`default_nettype none

module tick_gen
#(
  parameter tick_log = 26
)
(
  input  wire  clk,
  input  wire  rst_n,
  output logic tick
);

  //----------------------------------------------------------------------
  // free-running cycle counter

  logic [tick_log - 1:0] cnt;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cnt <= '0;
    end
    else
    begin
      // wraps to zero on its own after all ones
      cnt <= cnt + 1'b1;
    end
  end

  // tick on the last count of each period
  // stands in for a divided clock, so the whole design stays on clk
  assign tick = &cnt;

endmodule

`default_nettype wire

//--- key_request.sv
// key request decoder, synchronizes active-low keys and makes qualified push and pop pulses
`timescale 1ns/100ps
`default_nettype none

module key_request
  import fifo_demo_pkg::*;
#(
  parameter w_key = 4
)
(
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire [w_key - 1:0]   key,
  input  wire                 tick,
  input  wire                 full,
  input  wire                 empty,
  output logic                push,
  output logic                pop
);

  //----------------------------------------------------------------------
  // two-flop synchronizer, keys idle high

  logic [w_key - 1:0] key_meta;
  logic [w_key - 1:0] key_sync;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      key_meta <= '1;
      key_sync <= '1;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  //----------------------------------------------------------------------
  // pair decode

  logic push_pressed;
  logic pop_pressed;
  req_t request;

  // either key of a pair pulled low counts as a press
  assign push_pressed = (key_sync [3:2] != 2'b11);
  assign pop_pressed  = (key_sync [1:0] != 2'b11);

  always_comb
  begin
    case ({push_pressed, pop_pressed})
      2'b10:   request = req_push;
      2'b01:   request = req_pop;
      2'b11:   request = req_push_pop;
      default: request = req_idle;
    endcase
  end

  // only on the tick, and only when the fifo can take it
  // a blocked request is simply lost, nothing is queued
  always_comb
  begin
    push = 1'b0;
    pop  = 1'b0;
    if (tick)
    begin
      case (request)
        req_push:     push = ~full;
        req_pop:      pop  = ~empty;
        req_push_pop:
        begin
          push = ~full;
          pop  = ~empty;
        end
        default:      ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- pattern_source.sv
// push data source, walks the pattern table one step per accepted push
`timescale 1ns/100ps
`default_nettype none

module pattern_source
  import fifo_demo_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      push,
  output logic [fifo_width - 1:0]  write_data
);

  //----------------------------------------------------------------------
  // write index

  // 16-entry table, so a nibble-wide index wraps 15 -> 0 by itself
  logic [fifo_width - 1:0] wr_index;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_index <= '0;
    end
    else if (push)
    begin
      // advances with the same edge that stores the current value
      wr_index <= wr_index + 1'b1;
    end
  end

  //----------------------------------------------------------------------
  // table lookup

  // always shows the value the next push will store
  assign write_data = pattern_table [wr_index];

endmodule

`default_nettype wire

//--- fifo_ff_counter.sv
// flip-flop fifo with wrapping read and write pointers and an occupancy counter
`timescale 1ns/100ps
`default_nettype none

module fifo_ff_counter
  import fifo_demo_pkg::*;
#(
  parameter depth = 5
)
(
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             push,
  input  wire                             pop,
  input  wire  [fifo_width - 1:0]         write_data,
  output logic [fifo_width - 1:0]         read_data,
  output logic                            empty,
  output logic                            full,
  output logic [$clog2(depth + 1) - 1:0]  count,
  output logic [fifo_width - 1:0]         wr_ptr,
  output logic [fifo_width - 1:0]         rd_ptr
);

  // pointers are nibble wide so they can go straight to a display digit
  localparam logic [fifo_width - 1:0] last_ptr = fifo_width'(depth - 1);

  // low pointer bits that address one of the depth entries
  localparam int w_addr = (depth > 1) ? $clog2(depth) : 1;

  // step a pointer, wrapping after the last entry
  function automatic logic [fifo_width - 1:0] next_ptr (input logic [fifo_width - 1:0] ptr);
    logic [fifo_width - 1:0] nxt;
    if (ptr == last_ptr)
      nxt = '0;
    else
      nxt = ptr + 1'b1;
    return nxt;
  endfunction

  //----------------------------------------------------------------------
  // storage

  logic [fifo_width - 1:0] data [0:depth - 1];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < depth; i++)
        data [i] <= '0;
    end
    else if (push)
    begin
      data [wr_ptr [w_addr - 1:0]] <= write_data;
    end
  end

  // head entry, valid whenever empty is low
  assign read_data = data [rd_ptr [w_addr - 1:0]];

  //----------------------------------------------------------------------
  // pointers and occupancy

  // push on full and pop on empty are filtered upstream
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr (wr_ptr);
      if (pop)
        rd_ptr <= next_ptr (rd_ptr);

      // push and pop together leave count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // flags come straight from the counter
  assign empty = (count == '0);
  assign full  = (count == ($clog2(depth + 1))'(depth));

endmodule

`default_nettype wire

//--- fifo_display.sv
// multiplexed seven-segment driver for fifo state with empty and full sign overlay
`timescale 1ns/100ps
`default_nettype none

module fifo_display
  import fifo_demo_pkg::*;
#(
  parameter w_digit  = 8,
            scan_log = 10
)
(
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire [fifo_width - 1:0]   write_data,
  input  wire [fifo_width - 1:0]   wr_ptr,
  input  wire [fifo_width - 1:0]   rd_ptr,
  input  wire [fifo_width - 1:0]   read_data,
  input  wire                      empty,
  input  wire                      full,
  output logic [7:0]               abcdefgh,
  output logic [w_digit - 1:0]     digit
);

  localparam int w_sel = (w_digit > 1) ? $clog2(w_digit) : 1;

  //----------------------------------------------------------------------
  // scan timing

  logic [scan_log - 1:0] scan_cnt;
  logic [w_sel - 1:0]    sel;
  logic [w_sel - 1:0]    sel_next;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      scan_cnt <= '0;
    else
      scan_cnt <= scan_cnt + 1'b1;
  end

  // move to the next digit at the end of each scan period
  always_comb
  begin
    sel_next = sel;
    if (&scan_cnt)
    begin
      if (sel == w_sel'(w_digit - 1))
        sel_next = '0;
      else
        sel_next = sel + 1'b1;
    end
  end

  //----------------------------------------------------------------------
  // nibble and overlay for the digit about to be shown

  logic [fifo_width - 1:0] nibble;
  logic [7:0]              seg_next;

  // digit 0 is the rightmost, digits above 3 stay at zero
  always_comb
  begin
    case (sel_next)
      0:       nibble = read_data;
      1:       nibble = rd_ptr;
      2:       nibble = wr_ptr;
      3:       nibble = write_data;
      default: nibble = '0;
    endcase
  end

  always_comb
  begin
    if (sel_next == 0 && empty)
      seg_next = sign_empty;
    else if (sel_next == 3 && full)
      seg_next = sign_full;
    else
      seg_next = hex_segments (nibble);
  end

  //----------------------------------------------------------------------
  // output registers

  // select and segments load together so they never disagree
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sel      <= '0;
      digit    <= w_digit'(1);
      abcdefgh <= sign_empty;
    end
    else
    begin
      sel      <= sel_next;
      digit    <= w_digit'(1) << sel_next;
      abcdefgh <= seg_next;
    end
  end

endmodule

`default_nettype wire

//--- fifo_demo_top.sv
// fifo demo top level, keys push and pop a pattern fifo shown on leds and the display
`timescale 1ns/100ps
`default_nettype none

module fifo_demo_top
  import fifo_demo_pkg::*;
#(
  parameter tick_log   = 26,
            fifo_depth = 5,
            scan_log   = 10,
            w_key      = 4,
            w_led      = 8,
            w_digit    = 8
)
(
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire  [w_key   - 1:0]  key,
  output logic [w_led   - 1:0]  led,
  output logic [7:0]            abcdefgh,
  output logic [w_digit - 1:0]  digit
);

  localparam int w_count = $clog2(fifo_depth + 1);

  logic                    tick;
  logic                    push;
  logic                    pop;
  logic [fifo_width - 1:0] write_data;
  logic [fifo_width - 1:0] read_data;
  logic                    empty;
  logic                    full;
  logic [w_count - 1:0]    count;
  logic [fifo_width - 1:0] wr_ptr;
  logic [fifo_width - 1:0] rd_ptr;

  //----------------------------------------------------------------------
  // request path

  tick_gen #(.tick_log (tick_log)) i_tick_gen
  (
    .clk   (clk),
    .rst_n (rst_n),
    .tick  (tick)
  );

  key_request #(.w_key (w_key)) i_key_request
  (
    .clk   (clk),
    .rst_n (rst_n),
    .key   (key),
    .tick  (tick),
    .full  (full),
    .empty (empty),
    .push  (push),
    .pop   (pop)
  );

  pattern_source i_pattern_source
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .write_data (write_data)
  );

  //----------------------------------------------------------------------
  // fifo and outputs

  fifo_ff_counter #(.depth (fifo_depth)) i_fifo
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .pop        (pop),
    .write_data (write_data),
    .read_data  (read_data),
    .empty      (empty),
    .full       (full),
    .count      (count),
    .wr_ptr     (wr_ptr),
    .rd_ptr     (rd_ptr)
  );

  fifo_display #(.w_digit (w_digit), .scan_log (scan_log)) i_display
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .write_data (write_data),
    .wr_ptr     (wr_ptr),
    .rd_ptr     (rd_ptr),
    .read_data  (read_data),
    .empty      (empty),
    .full       (full),
    .abcdefgh   (abcdefgh),
    .digit      (digit)
  );

  // full on the leftmost led, then occupancy, head value on the right
  assign led = w_led'({full, count, read_data});

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// testbench clock source, free-running square wave of a given period
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
#(
  parameter period = 8
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
  end

  // half a period low, half a period high
  always
  begin
    #(period / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- tb_fifo_demo.sv
// fifo demo testbench, drives keys once per tick and checks leds and display against a queue model
`timescale 1ns/100ps
`default_nettype none

module tb_fifo_demo
  import fifo_demo_pkg::*;
();

  localparam int tick_log    = 3;
  localparam int fifo_depth  = 5;
  localparam int scan_log    = 2;
  localparam int w_digit     = 8;
  localparam int w_count     = $clog2(fifo_depth + 1);
  localparam int tick_period = 1 << tick_log;
  localparam int clk_period  = 8;
  // about 235 tick periods of operations and display scans
  localparam int op_count    = 240;
  localparam int watchdog_ns = (op_count + 10) * tick_period * clk_period + 10 * clk_period;

  // keys are active low, bits 3:2 push and bits 1:0 pop
  localparam logic [3:0] keys_idle = 4'b1111;
  localparam logic [3:0] keys_push = 4'b0111;
  localparam logic [3:0] keys_pop  = 4'b1110;
  localparam logic [3:0] keys_both = 4'b1010;

  logic                 clk;
  logic                 rst_n;
  logic [3:0]           key;
  logic [7:0]           led;
  logic [7:0]           abcdefgh;
  logic [w_digit - 1:0] digit;

  // cycles since reset release, tick cycles are those with cyc % 8 == 7
  int   cyc;
  req_t op_req;

  // reference model state
  logic [fifo_width - 1:0] model_q [$];
  logic [3:0]              model_index;
  int                      model_wr_ptr;
  int                      model_rd_ptr;
  logic [7:0]              exp_led;

  string test_name;
  int    check_count;
  int    err_count;
  int    check_mark;
  int    err_mark;
  int    seed = 81;
  int    rnd;

  tb_clock_gen #(.period (clk_period)) i_clock (.clk (clk));

  fifo_demo_top
  #(
    .tick_log   (tick_log),
    .fifo_depth (fifo_depth),
    .scan_log   (scan_log),
    .w_key      (4),
    .w_led      (8),
    .w_digit    (w_digit)
  )
  UUT
  (
    .clk      (clk),
    .rst_n    (rst_n),
    .key      (key),
    .led      (led),
    .abcdefgh (abcdefgh),
    .digit    (digit)
  );

  //----------------------------------------------------------------------
  // reference model

  // either key of a pair held low means that pair is pressed
  function automatic req_t key_to_req (input logic [3:0] k);
    req_t req;
    case ({k[3:2] != 2'b11, k[1:0] != 2'b11})
      2'b10:   req = req_push;
      2'b01:   req = req_pop;
      2'b11:   req = req_push_pop;
      default: req = req_idle;
    endcase
    return req;
  endfunction

  // one tick of the model, returns {full, count, head}
  function automatic logic [7:0] next_led (input req_t req);
    logic                    do_push;
    logic                    do_pop;
    logic [fifo_width - 1:0] head;
    int                      level;
    // both flags judged on the state before the tick
    do_push = (req == req_push || req == req_push_pop) && model_q.size() < fifo_depth;
    do_pop  = (req == req_pop || req == req_push_pop) && model_q.size() > 0;
    if (do_pop)
    begin
      void'(model_q.pop_front());
      model_rd_ptr = (model_rd_ptr + 1) % fifo_depth;
    end
    if (do_push)
    begin
      model_q.push_back(pattern_table[model_index]);
      model_index  = model_index + 4'd1;
      model_wr_ptr = (model_wr_ptr + 1) % fifo_depth;
    end
    level = model_q.size();
    head  = (level > 0) ? model_q[0] : 4'h0;
    return {level == fifo_depth, w_count'(level), head};
  endfunction

  // segments expected on a digit, signs replace digits 0 and 3
  function automatic logic [7:0] expected_segments (input int sel);
    logic [7:0] seg;
    case (sel)
      0:       seg = (model_q.size() == 0) ? sign_empty : hex_segments(model_q[0]);
      1:       seg = hex_segments(4'(model_rd_ptr));
      2:       seg = hex_segments(4'(model_wr_ptr));
      3:       seg = (model_q.size() == fifo_depth) ? sign_full
                                                    : hex_segments(pattern_table[model_index]);
      default: seg = hex_segments(4'h0);
    endcase
    return seg;
  endfunction

  //----------------------------------------------------------------------
  // checks

  task automatic compare_value (input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
    check_count++;
    if (actual !== expected)
    begin
      err_count++;
      $display("[FAIL] %s expected 0x%02h actual 0x%02h", name, expected, actual);
    end
  endtask

  always @(posedge clk)
  begin
    if (!rst_n)
      cyc <= 0;
    else
      cyc <= cyc + 1;
  end

  // the cycle after each tick, the model takes the request of that tick
  always @(negedge clk)
  begin
    if (rst_n && cyc > 0 && cyc % tick_period == 0)
    begin
      exp_led = next_led(op_req);
      compare_value({test_name, " count and full"}, {4'h0, exp_led[7:4]}, {4'h0, led[7:4]});
      // storage is stale while empty, so the head is only checked when valid
      if (model_q.size() > 0)
        compare_value({test_name, " head"}, {4'h0, exp_led[3:0]}, {4'h0, led[3:0]});
    end
  end

  //----------------------------------------------------------------------
  // stimulus helpers

  // keys change on the falling edge just after a tick and hold for one period
  task automatic apply_keys (input logic [3:0] k);
    @(negedge clk);
    while (cyc % tick_period != 1)
      @(negedge clk);
    key    = k;
    op_req = key_to_req(k);
  endtask

  // one full scan with the fifo at rest, every digit compared
  task automatic scan_display;
    int                   sel;
    logic [w_digit - 1:0] seen;
    seen = '0;
    repeat (w_digit * (1 << scan_log))
    begin
      @(negedge clk);
      sel = 0;
      for (int i = 0; i < w_digit; i++)
      begin
        if (digit == (w_digit'(1) << i))
          sel = i;
      end
      compare_value({test_name, " one-hot digit"}, 8'd1, 8'($countones(digit)));
      compare_value({test_name, " segments"}, expected_segments(sel), abcdefgh);
      seen = seen | digit;
    end
    compare_value({test_name, " digits visited"}, 8'hff, 8'(seen));
  endtask

  task automatic start_test (input string name);
    test_name  = name;
    check_mark = check_count;
    err_mark   = err_count;
  endtask

  task automatic end_test;
    $display("test %s: %0d checks, %0d errors", test_name,
             check_count - check_mark, err_count - err_mark);
  endtask

  //----------------------------------------------------------------------
  // test sequence

  initial
  begin
    rst_n        = 1'b0;
    key          = keys_idle;
    op_req       = req_idle;
    model_index  = 4'h0;
    model_wr_ptr = 0;
    model_rd_ptr = 0;
    check_count  = 0;
    err_count    = 0;

    start_test("reset");
    repeat (10) @(negedge clk);
    // full low, count zero and head zero
    compare_value("reset led", 8'h00, led);
    compare_value("reset digit", 8'h01, 8'(digit));
    compare_value("reset segments", sign_empty, abcdefgh);
    end_test;
    rst_n = 1'b1;

    // six pushes, the last one meets a full fifo and is dropped
    start_test("push");
    repeat (6) apply_keys(keys_push);
    apply_keys(keys_idle);
    scan_display;
    end_test;

    // drains 2 6 d b 7, then one pop on empty
    // digit 3 then shows e only if the index moved five times
    start_test("pop");
    repeat (6) apply_keys(keys_pop);
    apply_keys(keys_idle);
    scan_display;
    end_test;

    start_test("push_pop");
    repeat (2) apply_keys(keys_push);
    repeat (3) apply_keys(keys_both);
    apply_keys(keys_idle);
    end_test;

    start_test("random");
    repeat (200)
    begin
      rnd = $random(seed);
      apply_keys(rnd[3:0]);
    end
    apply_keys(keys_idle);
    end_test;

    // bring the fifo to a partly filled state before the scan
    start_test("display");
    if (model_q.size() == 0)
      apply_keys(keys_push);
    else if (model_q.size() == fifo_depth)
      apply_keys(keys_pop);
    apply_keys(keys_idle);
    scan_display;
    end_test;

    $display("total: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    #(watchdog_ns);
    $display("run timed out after %0d ns before all tests finished", watchdog_ns);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
fifo_demo_pkg.sv
tick_gen.sv
key_request.sv
pattern_source.sv
fifo_ff_counter.sv
fifo_display.sv
fifo_demo_top.sv
tb_clock_gen.sv
tb_fifo_demo.sv

//--- run.sh
#!/bin/sh
# build and run the fifo demo testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_fifo_demo -f all.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_fifo_demo > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
